/* mdu_pkg.sv */
package mdu_pkg;

  // datapath
  localparam int data_width = 32;
  typedef logic [data_width-1:0] data_t;

  // ROB index, doubles as the CDB reference id
  localparam int rob_addr_width = 4;
  typedef logic [rob_addr_width-1:0] rob_addr_t;

  // reservation station
  localparam int rs_size = 8;
  localparam int rs_addr_width = 3;
  typedef logic [rs_addr_width-1:0] rs_addr_t;

  // operation codes
  localparam int mdu_op_width = 2;
  typedef logic [mdu_op_width-1:0] mdu_op_t;

  localparam mdu_op_t op_mul = 2'd0;
  localparam mdu_op_t op_mulu = 2'd1;
  localparam mdu_op_t op_div = 2'd2;
  localparam mdu_op_t op_divu = 2'd3;

  // one line of the station
  typedef enum logic [2:0] {
    rs_none,
    rs_wait,
    rs_ready,
    rs_busy,
    rs_commit
  } rs_state_t;

  // iterative unit
  typedef enum logic [1:0] {
    mdu_idle,
    mdu_run,
    mdu_done
  } mdu_state_t;

  // one bit per step, plus a sign fix cycle after the last one
  localparam int mdu_steps = 32;

endpackage

/* rs_line.sv */
`timescale 1ns/1ps

module rs_line (
  input  logic                clk,
  input  logic                reset,
  input  logic                write_en,
  input  mdu_pkg::rob_addr_t  rob_addr_in,
  input  mdu_pkg::mdu_op_t    op_in,
  input  logic                operand_is_ref_1,
  input  logic                operand_is_ref_2,
  input  mdu_pkg::data_t      operand_data_1_in,
  input  mdu_pkg::data_t      operand_data_2_in,
  input  logic                bus_en,
  input  mdu_pkg::rob_addr_t  bus_ref_id,
  input  mdu_pkg::data_t      bus_data,
  input  logic                issue_en,
  input  logic                result_en,
  input  mdu_pkg::data_t      result_hi,
  input  mdu_pkg::data_t      result_lo,
  input  logic                invalidate_en,
  output mdu_pkg::rs_state_t  state,
  output mdu_pkg::rob_addr_t  rob_addr_out,
  output mdu_pkg::mdu_op_t    op_out,
  output mdu_pkg::data_t      operand_data_1_out,
  output mdu_pkg::data_t      operand_data_2_out,
  output mdu_pkg::data_t      result_hi_out,
  output mdu_pkg::data_t      result_lo_out
);

  logic ref_1;
  logic ref_2;
  logic match_in_1;
  logic match_in_2;
  logic match_1;
  logic match_2;

  // a pending operand keeps the producer's ROB address in its low bits
  assign match_in_1 = bus_en && operand_is_ref_1 &&
                      operand_data_1_in[mdu_pkg::rob_addr_width-1:0] == bus_ref_id;
  assign match_in_2 = bus_en && operand_is_ref_2 &&
                      operand_data_2_in[mdu_pkg::rob_addr_width-1:0] == bus_ref_id;
  assign match_1 = bus_en && ref_1 &&
                   operand_data_1_out[mdu_pkg::rob_addr_width-1:0] == bus_ref_id;
  assign match_2 = bus_en && ref_2 &&
                   operand_data_2_out[mdu_pkg::rob_addr_width-1:0] == bus_ref_id;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= mdu_pkg::rs_none;
      ref_1 <= 1'b0;
      ref_2 <= 1'b0;
    end else begin
      unique case (state)
        mdu_pkg::rs_none: begin
          if (write_en) begin
            ref_1 <= operand_is_ref_1 && !match_in_1;
            ref_2 <= operand_is_ref_2 && !match_in_2;
            // a same-edge broadcast still goes through rs_wait
            if (operand_is_ref_1 || operand_is_ref_2) begin
              state <= mdu_pkg::rs_wait;
            end else begin
              state <= mdu_pkg::rs_ready;
            end
          end
        end
        mdu_pkg::rs_wait: begin
          if (match_1) ref_1 <= 1'b0;
          if (match_2) ref_2 <= 1'b0;
          if (!ref_1 && !ref_2) state <= mdu_pkg::rs_ready;
        end
        mdu_pkg::rs_ready: begin
          if (issue_en) state <= mdu_pkg::rs_busy;
        end
        mdu_pkg::rs_busy: begin
          if (result_en) state <= mdu_pkg::rs_commit;
        end
        mdu_pkg::rs_commit: begin
          if (invalidate_en) state <= mdu_pkg::rs_none;
        end
        default: state <= mdu_pkg::rs_none;
      endcase
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (state == mdu_pkg::rs_none && write_en) begin
      rob_addr_out <= rob_addr_in;
      op_out <= op_in;
      operand_data_1_out <= match_in_1 ? bus_data : operand_data_1_in;
      operand_data_2_out <= match_in_2 ? bus_data : operand_data_2_in;
    end else if (state == mdu_pkg::rs_wait) begin
      if (match_1) operand_data_1_out <= bus_data;
      if (match_2) operand_data_2_out <= bus_data;
    end
    if (state == mdu_pkg::rs_busy && result_en) begin
      result_hi_out <= result_hi;
      result_lo_out <= result_lo;
    end
  end

  // the station only issues ready lines, and the unit only answers busy ones
  assert property (@(posedge clk) disable iff (reset)
    issue_en |-> state == mdu_pkg::rs_ready);
  assert property (@(posedge clk) disable iff (reset)
    result_en |-> state == mdu_pkg::rs_busy);

endmodule

/* rs_mdu.sv */
`timescale 1ns/1ps

module rs_mdu (
  input  logic                clk,
  input  logic                reset,
  // write channel
  input  logic                write_en,
  output logic                can_write,
  input  mdu_pkg::rob_addr_t  rob_addr_in,
  input  mdu_pkg::mdu_op_t    op_in,
  input  logic                operand_is_ref_1,
  input  logic                operand_is_ref_2,
  input  mdu_pkg::data_t      operand_data_1_in,
  input  mdu_pkg::data_t      operand_data_2_in,
  // CDB
  input  logic                bus_en,
  input  mdu_pkg::rob_addr_t  bus_ref_id,
  input  mdu_pkg::data_t      bus_data,
  // issue to the unit
  output logic                issue_valid,
  input  logic                mdu_ready,
  output mdu_pkg::rs_addr_t   issue_rs_addr,
  output mdu_pkg::mdu_op_t    issue_op,
  output mdu_pkg::data_t      issue_operand_1,
  output mdu_pkg::data_t      issue_operand_2,
  // result from the unit
  input  logic                result_en,
  input  mdu_pkg::rs_addr_t   result_rs_addr,
  input  mdu_pkg::data_t      result_hi,
  input  mdu_pkg::data_t      result_lo,
  // commit to the ROB
  output logic                can_commit,
  input  logic                rob_commit_en,
  output mdu_pkg::rob_addr_t  rob_commit_addr,
  output mdu_pkg::data_t      rob_commit_data,
  output mdu_pkg::data_t      rob_commit_lo_data
);

  mdu_pkg::rs_state_t line_state [mdu_pkg::rs_size];
  mdu_pkg::rob_addr_t line_rob_addr [mdu_pkg::rs_size];
  mdu_pkg::mdu_op_t   line_op [mdu_pkg::rs_size];
  mdu_pkg::data_t     line_operand_1 [mdu_pkg::rs_size];
  mdu_pkg::data_t     line_operand_2 [mdu_pkg::rs_size];
  mdu_pkg::data_t     line_result_hi [mdu_pkg::rs_size];
  mdu_pkg::data_t     line_result_lo [mdu_pkg::rs_size];

  logic [mdu_pkg::rs_size-1:0] free_mask;
  logic [mdu_pkg::rs_size-1:0] ready_mask;
  logic [mdu_pkg::rs_size-1:0] commit_mask;
  logic [mdu_pkg::rs_size-1:0] line_write_en;
  logic [mdu_pkg::rs_size-1:0] line_issue_en;
  logic [mdu_pkg::rs_size-1:0] line_result_en;
  logic [mdu_pkg::rs_size-1:0] line_invalidate_en;

  mdu_pkg::rs_addr_t free_idx;
  mdu_pkg::rs_addr_t ready_idx;
  mdu_pkg::rs_addr_t commit_idx;

  // lowest set bit wins
  function automatic mdu_pkg::rs_addr_t first_set(input logic [mdu_pkg::rs_size-1:0] mask);
    mdu_pkg::rs_addr_t idx;
    idx = '0;
    for (int k = mdu_pkg::rs_size - 1; k >= 0; k--) begin
      if (mask[k]) idx = mdu_pkg::rs_addr_t'(k);
    end
    return idx;
  endfunction

  assign free_idx = first_set(free_mask);
  assign ready_idx = first_set(ready_mask);
  assign commit_idx = first_set(commit_mask);

  assign can_write = |free_mask;
  assign issue_valid = |ready_mask;
  assign can_commit = |commit_mask;

  assign issue_rs_addr = ready_idx;
  assign issue_op = line_op[ready_idx];
  assign issue_operand_1 = line_operand_1[ready_idx];
  assign issue_operand_2 = line_operand_2[ready_idx];

  assign rob_commit_addr = line_rob_addr[commit_idx];
  assign rob_commit_data = line_result_hi[commit_idx];
  assign rob_commit_lo_data = line_result_lo[commit_idx];

  for (genvar i = 0; i < mdu_pkg::rs_size; i++) begin : g_line
    assign free_mask[i] = line_state[i] == mdu_pkg::rs_none;
    assign ready_mask[i] = line_state[i] == mdu_pkg::rs_ready;
    assign commit_mask[i] = line_state[i] == mdu_pkg::rs_commit;

    assign line_write_en[i] = write_en && can_write && free_idx == i;
    assign line_issue_en[i] = issue_valid && mdu_ready && ready_idx == i;
    assign line_result_en[i] = result_en && result_rs_addr == i;
    assign line_invalidate_en[i] = rob_commit_en && can_commit && commit_idx == i;

    rs_line line_inst (
      .clk                (clk),
      .reset              (reset),
      .write_en           (line_write_en[i]),
      .rob_addr_in        (rob_addr_in),
      .op_in              (op_in),
      .operand_is_ref_1   (operand_is_ref_1),
      .operand_is_ref_2   (operand_is_ref_2),
      .operand_data_1_in  (operand_data_1_in),
      .operand_data_2_in  (operand_data_2_in),
      .bus_en             (bus_en),
      .bus_ref_id         (bus_ref_id),
      .bus_data           (bus_data),
      .issue_en           (line_issue_en[i]),
      .result_en          (line_result_en[i]),
      .result_hi          (result_hi),
      .result_lo          (result_lo),
      .invalidate_en      (line_invalidate_en[i]),
      .state              (line_state[i]),
      .rob_addr_out       (line_rob_addr[i]),
      .op_out             (line_op[i]),
      .operand_data_1_out (line_operand_1[i]),
      .operand_data_2_out (line_operand_2[i]),
      .result_hi_out      (line_result_hi[i]),
      .result_lo_out      (line_result_lo[i])
    );
  end

  // an ignored write must not take a line: the station stays full
  // unless a commit freed one on that edge
  assert property (@(posedge clk) disable iff (reset)
    (write_en && !can_write) |=> (free_mask == '0 || $past(rob_commit_en && can_commit)));

endmodule

/* mdu.sv */
`timescale 1ns/1ps

module mdu (
  input  logic                clk,
  input  logic                reset,
  input  logic                issue_valid,
  input  mdu_pkg::rs_addr_t   issue_rs_addr,
  input  mdu_pkg::mdu_op_t    issue_op,
  input  mdu_pkg::data_t      issue_operand_1,
  input  mdu_pkg::data_t      issue_operand_2,
  output logic                mdu_ready,
  output logic                result_en,
  output mdu_pkg::rs_addr_t   result_rs_addr,
  output mdu_pkg::data_t      result_hi,
  output mdu_pkg::data_t      result_lo
);

  mdu_pkg::mdu_state_t state;
  logic [$clog2(mdu_pkg::mdu_steps):0] count;

  logic           issue_fire;
  logic           in_signed;
  logic           sign_a;
  logic           sign_b;
  mdu_pkg::data_t abs_a;
  mdu_pkg::data_t abs_b;

  logic           is_div;
  logic           neg_hi;
  logic           neg_lo;
  mdu_pkg::data_t b_reg;

  logic [mdu_pkg::data_width:0]     mul_sum;
  logic [mdu_pkg::data_width:0]     div_shift;
  logic [mdu_pkg::data_width+1:0]   div_diff;
  logic [2*mdu_pkg::data_width-1:0] product;
  mdu_pkg::data_t step_hi;
  mdu_pkg::data_t step_lo;
  mdu_pkg::data_t fix_hi;
  mdu_pkg::data_t fix_lo;

  assign mdu_ready = state == mdu_pkg::mdu_idle;
  assign result_en = state == mdu_pkg::mdu_done;
  assign issue_fire = issue_valid && mdu_ready;

  // magnitudes for signed ops
  assign in_signed = issue_op == mdu_pkg::op_mul || issue_op == mdu_pkg::op_div;
  assign sign_a = in_signed && issue_operand_1[mdu_pkg::data_width-1];
  assign sign_b = in_signed && issue_operand_2[mdu_pkg::data_width-1];
  assign abs_a = sign_a ? -issue_operand_1 : issue_operand_1;
  assign abs_b = sign_b ? -issue_operand_2 : issue_operand_2;

  always_comb begin
    // shift-add with hi accumulating while the multiplier shifts out of lo
    mul_sum = {1'b0, result_hi} + {1'b0, result_lo[0] ? b_reg : '0};
    // restoring divide keeps the remainder in hi and builds the quotient in lo
    div_shift = {result_hi, result_lo[mdu_pkg::data_width-1]};
    div_diff = {1'b0, div_shift} - {2'b00, b_reg};
    if (is_div) begin
      if (!div_diff[mdu_pkg::data_width+1]) begin
        step_hi = div_diff[mdu_pkg::data_width-1:0];
        step_lo = {result_lo[mdu_pkg::data_width-2:0], 1'b1};
      end else begin
        step_hi = div_shift[mdu_pkg::data_width-1:0];
        step_lo = {result_lo[mdu_pkg::data_width-2:0], 1'b0};
      end
    end else begin
      step_hi = mul_sum[mdu_pkg::data_width:1];
      step_lo = {mul_sum[0], result_lo[mdu_pkg::data_width-1:1]};
    end

    // sign fix
    product = neg_lo ? -{result_hi, result_lo} : {result_hi, result_lo};
    if (is_div) begin
      fix_hi = neg_hi ? -result_hi : result_hi;
      fix_lo = neg_lo ? -result_lo : result_lo;
    end else begin
      fix_hi = product[2*mdu_pkg::data_width-1:mdu_pkg::data_width];
      fix_lo = product[mdu_pkg::data_width-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= mdu_pkg::mdu_idle;
      count <= '0;
    end else begin
      unique case (state)
        mdu_pkg::mdu_idle: begin
          count <= '0;
          if (issue_fire) state <= mdu_pkg::mdu_run;
        end
        mdu_pkg::mdu_run: begin
          count <= count + 1'b1;
          if (count == mdu_pkg::mdu_steps) state <= mdu_pkg::mdu_done;
        end
        default: state <= mdu_pkg::mdu_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue_fire) begin
      is_div <= issue_op == mdu_pkg::op_div || issue_op == mdu_pkg::op_divu;
      result_rs_addr <= issue_rs_addr;
      b_reg <= abs_b;
      result_hi <= '0;
      result_lo <= abs_a;
      // remainder follows the dividend and everything else the sign product
      if (issue_op == mdu_pkg::op_div || issue_op == mdu_pkg::op_divu) begin
        neg_hi <= sign_a;
        neg_lo <= (sign_a ^ sign_b) && issue_operand_2 != '0;
      end else begin
        neg_hi <= sign_a ^ sign_b;
        neg_lo <= sign_a ^ sign_b;
      end
    end else if (state == mdu_pkg::mdu_run) begin
      if (count < mdu_pkg::mdu_steps) begin
        result_hi <= step_hi;
        result_lo <= step_lo;
      end else begin
        result_hi <= fix_hi;
        result_lo <= fix_lo;
      end
    end
  end

  // fixed latency and a single-cycle result strobe
  assert property (@(posedge clk) disable iff (reset)
    issue_fire |-> ##(mdu_pkg::mdu_steps + 2) result_en ##1 !result_en);

endmodule

/* mdu_cluster.sv */
`timescale 1ns/1ps

module mdu_cluster (
  input  logic                clk,
  input  logic                reset,
  // write channel
  input  logic                write_en,
  output logic                can_write,
  input  mdu_pkg::rob_addr_t  rob_addr_in,
  input  mdu_pkg::mdu_op_t    op_in,
  input  logic                operand_is_ref_1,
  input  logic                operand_is_ref_2,
  input  mdu_pkg::data_t      operand_data_1_in,
  input  mdu_pkg::data_t      operand_data_2_in,
  // CDB
  input  logic                bus_en,
  input  mdu_pkg::rob_addr_t  bus_ref_id,
  input  mdu_pkg::data_t      bus_data,
  // commit to the ROB
  output logic                can_commit,
  input  logic                rob_commit_en,
  output mdu_pkg::rob_addr_t  rob_commit_addr,
  output mdu_pkg::data_t      rob_commit_data,
  output mdu_pkg::data_t      rob_commit_lo_data
);

  logic              issue_valid;
  logic              mdu_ready;
  mdu_pkg::rs_addr_t issue_rs_addr;
  mdu_pkg::mdu_op_t  issue_op;
  mdu_pkg::data_t    issue_operand_1;
  mdu_pkg::data_t    issue_operand_2;
  logic              result_en;
  mdu_pkg::rs_addr_t result_rs_addr;
  mdu_pkg::data_t    result_hi;
  mdu_pkg::data_t    result_lo;

  rs_mdu rs_inst (
    .clk                (clk),
    .reset              (reset),
    .write_en           (write_en),
    .can_write          (can_write),
    .rob_addr_in        (rob_addr_in),
    .op_in              (op_in),
    .operand_is_ref_1   (operand_is_ref_1),
    .operand_is_ref_2   (operand_is_ref_2),
    .operand_data_1_in  (operand_data_1_in),
    .operand_data_2_in  (operand_data_2_in),
    .bus_en             (bus_en),
    .bus_ref_id         (bus_ref_id),
    .bus_data           (bus_data),
    .issue_valid        (issue_valid),
    .mdu_ready          (mdu_ready),
    .issue_rs_addr      (issue_rs_addr),
    .issue_op           (issue_op),
    .issue_operand_1    (issue_operand_1),
    .issue_operand_2    (issue_operand_2),
    .result_en          (result_en),
    .result_rs_addr     (result_rs_addr),
    .result_hi          (result_hi),
    .result_lo          (result_lo),
    .can_commit         (can_commit),
    .rob_commit_en      (rob_commit_en),
    .rob_commit_addr    (rob_commit_addr),
    .rob_commit_data    (rob_commit_data),
    .rob_commit_lo_data (rob_commit_lo_data)
  );

  mdu mdu_inst (
    .clk             (clk),
    .reset           (reset),
    .issue_valid     (issue_valid),
    .issue_rs_addr   (issue_rs_addr),
    .issue_op        (issue_op),
    .issue_operand_1 (issue_operand_1),
    .issue_operand_2 (issue_operand_2),
    .mdu_ready       (mdu_ready),
    .result_en       (result_en),
    .result_rs_addr  (result_rs_addr),
    .result_hi       (result_hi),
    .result_lo       (result_lo)
  );

endmodule

/* mdu_cluster_checker.sv */
`timescale 1ns/1ps

module mdu_cluster_checker (
  input  logic                clk,
  input  logic                reset,
  input  logic                can_write,
  input  logic                can_commit,
  input  logic                rob_commit_en,
  input  mdu_pkg::rob_addr_t  rob_commit_addr,
  input  mdu_pkg::data_t      rob_commit_data,
  input  mdu_pkg::data_t      rob_commit_lo_data
);

  // expectations, keyed by ROB address
  string          name_of [2**mdu_pkg::rob_addr_width];
  logic           pending [2**mdu_pkg::rob_addr_width];
  logic           waiting_bus [2**mdu_pkg::rob_addr_width];
  mdu_pkg::data_t exp_hi_of [2**mdu_pkg::rob_addr_width];
  mdu_pkg::data_t exp_lo_of [2**mdu_pkg::rob_addr_width];

  int pass_count;
  int fail_count;
  int outstanding_count;

  // offer seen last cycle that the ROB did not take
  logic               held;
  mdu_pkg::rob_addr_t held_addr;
  mdu_pkg::data_t     held_hi;
  mdu_pkg::data_t     held_lo;

  initial begin
    pass_count = 0;
    fail_count = 0;
    outstanding_count = 0;
    held = 1'b0;
    for (int k = 0; k < 2**mdu_pkg::rob_addr_width; k++) begin
      pending[k] = 1'b0;
      waiting_bus[k] = 1'b0;
    end
  end

  task automatic expect_result(input string name, input mdu_pkg::rob_addr_t rob,
                               input mdu_pkg::data_t hi, input mdu_pkg::data_t lo,
                               input logic needs_bus);
    name_of[rob] = name;
    exp_hi_of[rob] = hi;
    exp_lo_of[rob] = lo;
    waiting_bus[rob] = needs_bus;
    pending[rob] = 1'b1;
    outstanding_count++;
  endtask

  task automatic mark_broadcast(input mdu_pkg::rob_addr_t rob);
    waiting_bus[rob] = 1'b0;
  endtask

  task automatic check_reset_state();
    if (can_write === 1'b1 && can_commit === 1'b0) begin
      pass_count++;
      $display("Pass reset_state can_write 1 can_commit 0");
    end else begin
      fail_count++;
      $display("Fail reset_state expected can_write 1 can_commit 0 actual %b %b",
               can_write, can_commit);
    end
  endtask

  task automatic check_rejected(input string name);
    if (can_write === 1'b0) begin
      pass_count++;
      $display("Pass %s can_write 0 with the station full", name);
    end else begin
      fail_count++;
      $display("Fail %s expected can_write 0 actual %b", name, can_write);
    end
  endtask

  task automatic record_commit();
    mdu_pkg::rob_addr_t a;
    a = rob_commit_addr;
    if (!pending[a]) begin
      fail_count++;
      $display("ROB address %0d committed with no result outstanding for it", a);
    end else begin
      pending[a] = 1'b0;
      outstanding_count--;
      if (waiting_bus[a]) begin
        fail_count++;
        $display("%s committed before its operand was broadcast on the CDB", name_of[a]);
      end else if (rob_commit_data === exp_hi_of[a] && rob_commit_lo_data === exp_lo_of[a]) begin
        pass_count++;
        $display("Pass %s hi %h lo %h", name_of[a], rob_commit_data, rob_commit_lo_data);
      end else begin
        fail_count++;
        $display("Fail %s expected %h %h actual %h %h", name_of[a], exp_hi_of[a],
                 exp_lo_of[a], rob_commit_data, rob_commit_lo_data);
      end
    end
  endtask

  // inputs settle 2 ns after the rising edge, the commit lands on the next one
  always @(negedge clk) begin
    if (!reset) begin
      if (held && can_commit !== 1'b1) begin
        fail_count++;
        $display("can_commit dropped while ROB address %0d was held off", held_addr);
      end else if (held && rob_commit_addr == held_addr &&
                   (rob_commit_data !== held_hi || rob_commit_lo_data !== held_lo)) begin
        fail_count++;
        $display("commit data of ROB address %0d changed while held off", held_addr);
      end
      if (can_commit && rob_commit_en) record_commit();
      held = can_commit && !rob_commit_en;
      held_addr = rob_commit_addr;
      held_hi = rob_commit_data;
      held_lo = rob_commit_lo_data;
    end
  end

  task automatic report_outstanding();
    for (int k = 0; k < 2**mdu_pkg::rob_addr_width; k++) begin
      if (pending[k]) $display("ROB address %0d (%s) still outstanding", k, name_of[k]);
    end
  endtask

  task automatic report_counts();
    $display("checks: %0d passed, %0d failed", pass_count, fail_count);
  endtask

endmodule

/* mdu_cluster_tb.sv */
`timescale 1ns/1ps

module mdu_cluster_tb;

  logic               clk;
  logic               reset;
  logic               write_en;
  logic               can_write;
  mdu_pkg::rob_addr_t rob_addr_in;
  mdu_pkg::mdu_op_t   op_in;
  logic               operand_is_ref_1;
  logic               operand_is_ref_2;
  mdu_pkg::data_t     operand_data_1_in;
  mdu_pkg::data_t     operand_data_2_in;
  logic               bus_en;
  mdu_pkg::rob_addr_t bus_ref_id;
  mdu_pkg::data_t     bus_data;
  logic               can_commit;
  logic               rob_commit_en;
  mdu_pkg::rob_addr_t rob_commit_addr;
  mdu_pkg::data_t     rob_commit_data;
  mdu_pkg::data_t     rob_commit_lo_data;

  // stimulus table
  string              names [32];
  mdu_pkg::rob_addr_t robs [32];
  mdu_pkg::mdu_op_t   ops [32];
  mdu_pkg::data_t     op_a [32];
  mdu_pkg::data_t     op_b [32];
  logic               is_ref_1 [32];
  logic               is_ref_2 [32];
  mdu_pkg::rob_addr_t ref_ids [32];
  int                 bus_delay [32];
  mdu_pkg::data_t     bus_vals [32];
  mdu_pkg::data_t     exp_hi [32];
  mdu_pkg::data_t     exp_lo [32];
  logic               drain [32];
  logic               burst [32];
  logic               reject [32];
  int                 n_entries = 0;
  int                 limit = 0;
  int                 cycles = 0;

  mdu_cluster UUT (
    .clk                (clk),
    .reset              (reset),
    .write_en           (write_en),
    .can_write          (can_write),
    .rob_addr_in        (rob_addr_in),
    .op_in              (op_in),
    .operand_is_ref_1   (operand_is_ref_1),
    .operand_is_ref_2   (operand_is_ref_2),
    .operand_data_1_in  (operand_data_1_in),
    .operand_data_2_in  (operand_data_2_in),
    .bus_en             (bus_en),
    .bus_ref_id         (bus_ref_id),
    .bus_data           (bus_data),
    .can_commit         (can_commit),
    .rob_commit_en      (rob_commit_en),
    .rob_commit_addr    (rob_commit_addr),
    .rob_commit_data    (rob_commit_data),
    .rob_commit_lo_data (rob_commit_lo_data)
  );

  mdu_cluster_checker result_checker (
    .clk                (clk),
    .reset              (reset),
    .can_write          (can_write),
    .can_commit         (can_commit),
    .rob_commit_en      (rob_commit_en),
    .rob_commit_addr    (rob_commit_addr),
    .rob_commit_data    (rob_commit_data),
    .rob_commit_lo_data (rob_commit_lo_data)
  );

  always #20 clk = ~clk;

  task automatic add_val(input string name, input mdu_pkg::mdu_op_t op,
                         input mdu_pkg::data_t a, input mdu_pkg::data_t b,
                         input mdu_pkg::data_t hi, input mdu_pkg::data_t lo);
    names[n_entries] = name;
    robs[n_entries] = mdu_pkg::rob_addr_t'(n_entries % 16);
    ops[n_entries] = op;
    op_a[n_entries] = a;
    op_b[n_entries] = b;
    is_ref_1[n_entries] = 1'b0;
    is_ref_2[n_entries] = 1'b0;
    ref_ids[n_entries] = '0;
    bus_delay[n_entries] = -1;
    bus_vals[n_entries] = '0;
    exp_hi[n_entries] = hi;
    exp_lo[n_entries] = lo;
    drain[n_entries] = 1'b0;
    burst[n_entries] = 1'b0;
    reject[n_entries] = 1'b0;
    n_entries++;
  endtask

  // a referenced operand carries the producer's ROB address as its data
  task automatic add_ref(input string name, input mdu_pkg::mdu_op_t op,
                         input logic r1, input logic r2, input mdu_pkg::data_t a,
                         input mdu_pkg::data_t b, input mdu_pkg::rob_addr_t id,
                         input int delay, input mdu_pkg::data_t data,
                         input mdu_pkg::data_t hi, input mdu_pkg::data_t lo);
    add_val(name, op, r1 ? mdu_pkg::data_t'(id) : a, r2 ? mdu_pkg::data_t'(id) : b, hi, lo);
    is_ref_1[n_entries-1] = r1;
    is_ref_2[n_entries-1] = r2;
    ref_ids[n_entries-1] = id;
    bus_delay[n_entries-1] = delay;
    bus_vals[n_entries-1] = data;
  endtask

  task automatic build_table();
    int fill_start;
    add_val("mul_small", mdu_pkg::op_mul, 32'd7, 32'd6, 32'h0, 32'h2a);
    add_val("mul_neg_pos", mdu_pkg::op_mul, 32'hfffffffd, 32'd5, 32'hffffffff, 32'hfffffff1);
    add_val("mul_pos_neg", mdu_pkg::op_mul, 32'd9, 32'hfffffffe, 32'hffffffff, 32'hffffffee);
    add_val("mulu_ones", mdu_pkg::op_mulu, 32'hffffffff, 32'hffffffff, 32'hfffffffe, 32'h1);
    add_val("mul_ones", mdu_pkg::op_mul, 32'hffffffff, 32'hffffffff, 32'h0, 32'h1);
    add_val("mulu_carry", mdu_pkg::op_mulu, 32'h80000000, 32'd2, 32'h1, 32'h0);
    add_val("mul_wide", mdu_pkg::op_mul, 32'h12345678, 32'h10, 32'h1, 32'h23456780);
    add_val("divu_small", mdu_pkg::op_divu, 32'd100, 32'd7, 32'h2, 32'he);
    add_val("div_neg_dividend", mdu_pkg::op_div, 32'hffffff9c, 32'd7, 32'hfffffffe, 32'hfffffff2);
    add_val("div_neg_divisor", mdu_pkg::op_div, 32'd100, 32'hfffffff9, 32'h2, 32'hfffffff2);
    add_val("div_both_neg", mdu_pkg::op_div, 32'hffffff9c, 32'hfffffff9, 32'hfffffffe, 32'he);
    add_val("divu_by_zero", mdu_pkg::op_divu, 32'h1234, 32'h0, 32'h1234, 32'hffffffff);
    add_val("div_by_zero", mdu_pkg::op_div, 32'hfffffffb, 32'h0, 32'hfffffffb, 32'hffffffff);
    add_val("divu_wide", mdu_pkg::op_divu, 32'hffffffff, 32'h10, 32'hf, 32'h0fffffff);
    add_ref("ref_first", mdu_pkg::op_mul, 1'b1, 1'b0, 32'h0, 32'd4, 4'd3, 6, 32'd25,
            32'h0, 32'h64);
    add_ref("ref_second", mdu_pkg::op_divu, 1'b0, 1'b1, 32'd1000, 32'h0, 4'd12, 3, 32'd30,
            32'ha, 32'h21);
    add_ref("ref_both", mdu_pkg::op_mulu, 1'b1, 1'b1, 32'h0, 32'h0, 4'd6, 4, 32'h10000,
            32'h1, 32'h0);
    add_ref("ref_same_edge", mdu_pkg::op_div, 1'b1, 1'b0, 32'h0, 32'hfffffffc, 4'd2, 0, 32'd17,
            32'h1, 32'hfffffffc);
    // eight back to back against a busy unit and then one write too many
    fill_start = n_entries;
    add_val("fill_mulu", mdu_pkg::op_mulu, 32'd3, 32'd5, 32'h0, 32'hf);
    add_val("fill_divu", mdu_pkg::op_divu, 32'd50, 32'd5, 32'h0, 32'ha);
    add_val("fill_mul_neg", mdu_pkg::op_mul, 32'hfffffffe, 32'hfffffffe, 32'h0, 32'h4);
    add_val("fill_div_neg", mdu_pkg::op_div, 32'hfffffff7, 32'd2, 32'hffffffff, 32'hfffffffc);
    add_val("fill_mulu_wide", mdu_pkg::op_mulu, 32'h10000, 32'h10000, 32'h1, 32'h0);
    add_val("fill_divu_small", mdu_pkg::op_divu, 32'd7, 32'd9, 32'h7, 32'h0);
    add_val("fill_mul_max", mdu_pkg::op_mul, 32'h7fffffff, 32'd2, 32'h0, 32'hfffffffe);
    add_val("fill_div_min", mdu_pkg::op_div, 32'h80000000, 32'd1, 32'h0, 32'h80000000);
    add_val("fill_reject", mdu_pkg::op_mulu, 32'd1, 32'd1, 32'h0, 32'h1);
    drain[fill_start] = 1'b1;
    for (int k = fill_start; k < n_entries; k++) burst[k] = 1'b1;
    reject[n_entries-1] = 1'b1;
  endtask

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic drive_bus(input mdu_pkg::rob_addr_t id, input mdu_pkg::data_t data);
    bus_en = 1'b1;
    bus_ref_id = id;
    bus_data = data;
  endtask

  task automatic apply_entry(input int i);
    int gap;
    if (drain[i]) begin
      while (result_checker.outstanding_count != 0) step();
    end
    if (!burst[i]) begin
      gap = $urandom % 4;
      repeat (gap) step();
    end
    if (reject[i]) begin
      result_checker.check_rejected(names[i]);
    end else begin
      while (!can_write || result_checker.pending[robs[i]]) step();
      result_checker.expect_result(names[i], robs[i], exp_hi[i], exp_lo[i],
                                   is_ref_1[i] || is_ref_2[i]);
    end
    write_en = 1'b1;
    rob_addr_in = robs[i];
    op_in = ops[i];
    operand_is_ref_1 = is_ref_1[i];
    operand_is_ref_2 = is_ref_2[i];
    operand_data_1_in = op_a[i];
    operand_data_2_in = op_b[i];
    // broadcast on the write edge itself
    if (bus_delay[i] == 0) begin
      drive_bus(ref_ids[i], bus_vals[i]);
      result_checker.mark_broadcast(robs[i]);
    end
    step();
    write_en = 1'b0;
    bus_en = 1'b0;
    for (int k = 1; k <= bus_delay[i]; k++) begin
      if (k == bus_delay[i]) begin
        drive_bus(ref_ids[i], bus_vals[i]);
        result_checker.mark_broadcast(robs[i]);
      end else if (k == 1) begin
        // another id first leaves the line waiting
        drive_bus(mdu_pkg::rob_addr_t'(ref_ids[i] + 1), 32'h5a5a5a5a);
      end
      step();
      bus_en = 1'b0;
    end
  endtask

  // ROB side that randomly holds off commits
  always @(posedge clk) begin
    int unsigned draw;
    #2;
    draw = $urandom % 3;
    rob_commit_en = !reset && draw != 0;
  end

  initial begin
    void'($urandom(34));
    clk = 1'b0;
    reset = 1'b1;
    write_en = 1'b0;
    rob_addr_in = '0;
    op_in = '0;
    operand_is_ref_1 = 1'b0;
    operand_is_ref_2 = 1'b0;
    operand_data_1_in = '0;
    operand_data_2_in = '0;
    bus_en = 1'b0;
    bus_ref_id = '0;
    bus_data = '0;
    rob_commit_en = 1'b0;
    build_table();
    limit = n_entries * 40 + 200;
    repeat (3) @(posedge clk);
    #2;
    reset = 1'b0;
    result_checker.check_reset_state();
    for (int i = 0; i < n_entries; i++) apply_entry(i);
    while (result_checker.outstanding_count != 0) step();
    // room for a wrongly accepted write to show up as a stray commit
    repeat (50) step();
    result_checker.report_counts();
    if (result_checker.fail_count == 0 && result_checker.pass_count > 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    @(posedge clk);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles", cycles);
    result_checker.report_outstanding();
    $display("test failed");
    $finish;
  end

endmodule

/* mdu_cluster.f */
mdu_pkg.sv
rs_line.sv
rs_mdu.sv
mdu.sv
mdu_cluster.sv
mdu_cluster_checker.sv
mdu_cluster_tb.sv

/* Bender.yml */
package:
  name: mdu_cluster

sources:
  - files:
      - mdu_pkg.sv
      - rs_line.sv
      - rs_mdu.sv
      - mdu.sv
      - mdu_cluster.sv
  - target: test
    files:
      - mdu_cluster_checker.sv
      - mdu_cluster_tb.sv
